// File: project.f
src/scale_pkg.sv
src/ps2_rx.sv
src/key_events.sv
src/scale_stepper.sv
src/tone_gen.sv
src/scale_player.sv
test/scale_player_tb.sv

// File: src/key_events.sv
`timescale 1ns/10ps

module key_events (
    input  logic             clk,
    input  logic             rst,
    input  scale_pkg::scan_t scan,
    input  logic             scan_valid,
    output logic             cmd_up,
    output logic             cmd_down,
    output logic             cmd_fast,
    output logic             cmd_slow,
    output logic             cmd_restart
);

    import scale_pkg::*;

    logic release_flag;     // an F0 was seen and the next code is a release.
    logic is_prefix;

    assign is_prefix = (scan == BREAK_PREFIX) || (scan == EXT_PREFIX);

    // ==============================
    // decoder
    // ==============================

    always_ff @(posedge clk) begin
        if (rst) begin
            release_flag <= 1'b0;
            cmd_up       <= 1'b0;
            cmd_down     <= 1'b0;
            cmd_fast     <= 1'b0;
            cmd_slow     <= 1'b0;
            cmd_restart  <= 1'b0;
        end else begin
            cmd_up      <= 1'b0;      // every command is a single-cycle pulse.
            cmd_down    <= 1'b0;
            cmd_fast    <= 1'b0;
            cmd_slow    <= 1'b0;
            cmd_restart <= 1'b0;
            if (scan_valid && is_prefix) begin
                if (scan == BREAK_PREFIX) begin
                    release_flag <= 1'b1;
                end
            end else if (scan_valid) begin
                release_flag <= 1'b0;
                // an extended code decodes like a plain one, so E0 5A restarts too.
                if (!release_flag) begin
                    case (scan)
                        KEY_W:     cmd_up      <= 1'b1;
                        KEY_S:     cmd_down    <= 1'b1;
                        KEY_R:     cmd_fast    <= 1'b1;
                        KEY_F:     cmd_slow    <= 1'b1;
                        KEY_ENTER: cmd_restart <= 1'b1;
                        default:   ;
                    endcase
                end
            end
        end
    end

    a_cmd_onehot: assert property (
        @(posedge clk) disable iff (rst)
        $onehot0({cmd_up, cmd_down, cmd_fast, cmd_slow, cmd_restart})
    );

endmodule

// File: src/ps2_rx.sv
`timescale 1ns/10ps

module ps2_rx #(
    parameter int CLK_HZ = 100_000_000
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             ps2_clk,
    input  logic             ps2_data,
    output scale_pkg::scan_t scan,
    output logic             scan_valid
);

    // a keyboard clocks bits at 10 to 17 kHz, so 100 us of silence inside a
    // frame means the frame was broken.
    localparam int TIMEOUT_RAW    = CLK_HZ / 10_000;
    localparam int TIMEOUT_CYCLES = (TIMEOUT_RAW > 2) ? TIMEOUT_RAW : 2;
    localparam int TO_W           = $clog2(TIMEOUT_CYCLES + 1);

    logic [1:0]      clk_sync;      // two-flop synchronizer for ps2_clk.
    logic [1:0]      data_sync;     // two-flop synchronizer for ps2_data.
    logic            clk_prev;      // last synchronized clock level.
    logic            fall;          // falling edge of the synchronized clock.
    logic [3:0]      bit_cnt;       // bits already taken from the current frame.
    logic [9:0]      shift;         // start, data and parity bits, lsb first.
    logic [TO_W-1:0] idle_cnt;      // cycles since the last clock edge.
    logic            frame_ok;

    // ==============================
    // synchronizers
    // ==============================

    always_ff @(posedge clk) begin
        if (rst) begin
            clk_sync  <= 2'b11;        // both lines idle high.
            data_sync <= 2'b11;
            clk_prev  <= 1'b1;
        end else begin
            clk_sync  <= {clk_sync[0], ps2_clk};
            data_sync <= {data_sync[0], ps2_data};
            clk_prev  <= clk_sync[1];
        end
    end

    assign fall = clk_prev & ~clk_sync[1];

    // ==============================
    // frame assembly
    // ==============================

    // checked on the stop bit, which is still on the data line.
    assign frame_ok = !shift[0] && data_sync[1] && (^shift[9:1]);

    always_ff @(posedge clk) begin
        if (rst) begin
            bit_cnt    <= '0;
            idle_cnt   <= '0;
            scan_valid <= 1'b0;
        end else begin
            scan_valid <= 1'b0;
            if (fall) begin
                idle_cnt <= '0;
                if (bit_cnt == 4'd10) begin
                    bit_cnt    <= '0;
                    scan_valid <= frame_ok;    // bad frames just vanish.
                end else begin
                    bit_cnt <= bit_cnt + 4'd1;
                end
            end else if (bit_cnt != 4'd0) begin
                if (idle_cnt == TO_W'(TIMEOUT_CYCLES - 1)) begin
                    bit_cnt  <= '0;            // give up on a half frame.
                    idle_cnt <= '0;
                end else begin
                    idle_cnt <= idle_cnt + 1'b1;
                end
            end
        end
    end

    // a full frame pushes any leftovers from an abandoned one out of the
    // shift register before the stop bit is reached.
    always_ff @(posedge clk) begin
        if (fall) begin
            if (bit_cnt == 4'd10) begin
                scan <= shift[8:1];
            end else begin
                shift <= {data_sync[1], shift[9:1]};
            end
        end
    end

    // a frame takes far longer than two cycles, so a byte is never doubled.
    a_valid_single: assert property (
        @(posedge clk) disable iff (rst) scan_valid |=> !scan_valid
    );

endmodule

// File: src/scale_pkg.sv
package scale_pkg;

    // ==============================
    // types
    // ==============================

    typedef logic [3:0] note_t;     // index into the note table.
    typedef logic [7:0] scan_t;     // one byte as it comes off the PS/2 wire.

    localparam note_t NOTE_LAST = 4'd14;    // C6, the top of the scale.

    // ==============================
    // scan codes
    // ==============================

    // make codes from scan code set 2.
    localparam scan_t KEY_W     = 8'h1D;
    localparam scan_t KEY_S     = 8'h1B;
    localparam scan_t KEY_R     = 8'h2D;
    localparam scan_t KEY_F     = 8'h2B;
    localparam scan_t KEY_ENTER = 8'h5A;

    localparam scan_t BREAK_PREFIX = 8'hF0;    // precedes the code of a released key.
    localparam scan_t EXT_PREFIX   = 8'hE0;    // precedes the code of an extended key.

    // ==============================
    // note frequencies
    // ==============================

    // the upper octave repeats the lower one at twice the frequency, so only
    // seven base values are kept. index 14 lands on step 7, which is C5,
    // and doubling it gives C6.
    function automatic logic [10:0] note_hz(input note_t n);
        logic [3:0]  step;
        logic [10:0] base;
        step = (n >= 4'd7) ? n - 4'd7 : n;
        case (step)
            4'd0:    base = 11'd262;
            4'd1:    base = 11'd294;
            4'd2:    base = 11'd330;
            4'd3:    base = 11'd349;
            4'd4:    base = 11'd392;
            4'd5:    base = 11'd440;
            4'd6:    base = 11'd494;
            default: base = 11'd524;
        endcase
        return (n >= 4'd7) ? base << 1 : base;
    endfunction

    // number of clock cycles the square wave stays at one level.
    function automatic logic [31:0] half_period(input note_t n, input int unsigned clk_hz);
        logic [31:0] hz;
        hz = 32'(note_hz(n));
        return 32'(clk_hz) / (32'd2 * hz);
    endfunction

endpackage

// File: src/scale_player.sv
`timescale 1ns/10ps

module scale_player #(
    parameter int CLK_HZ      = 100_000_000,
    parameter int STEP_CYCLES = 100_000_000
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             ps2_clk,
    input  logic             ps2_data,
    output logic             audio,
    output scale_pkg::note_t note,
    output logic             going_up,
    output logic             fast
);

    import scale_pkg::*;

    scan_t scan;            // byte from the receiver.
    logic  scan_valid;
    logic  cmd_up;
    logic  cmd_down;
    logic  cmd_fast;
    logic  cmd_slow;
    logic  cmd_restart;

    // ==============================
    // keyboard path
    // ==============================

    ps2_rx #(
        .CLK_HZ (CLK_HZ)
    ) ps2_rx_i (
        .clk        (clk),
        .rst        (rst),
        .ps2_clk    (ps2_clk),
        .ps2_data   (ps2_data),
        .scan       (scan),
        .scan_valid (scan_valid)
    );

    key_events key_events_i (
        .clk         (clk),
        .rst         (rst),
        .scan        (scan),
        .scan_valid  (scan_valid),
        .cmd_up      (cmd_up),
        .cmd_down    (cmd_down),
        .cmd_fast    (cmd_fast),
        .cmd_slow    (cmd_slow),
        .cmd_restart (cmd_restart)
    );

    // ==============================
    // scale and tone
    // ==============================

    scale_stepper #(
        .STEP_CYCLES (STEP_CYCLES)
    ) scale_stepper_i (
        .clk         (clk),
        .rst         (rst),
        .cmd_up      (cmd_up),
        .cmd_down    (cmd_down),
        .cmd_fast    (cmd_fast),
        .cmd_slow    (cmd_slow),
        .cmd_restart (cmd_restart),
        .note        (note),
        .going_up    (going_up),
        .fast        (fast)
    );

    tone_gen #(
        .CLK_HZ (CLK_HZ)
    ) tone_gen_i (
        .clk   (clk),
        .rst   (rst),
        .note  (note),
        .audio (audio)
    );

endmodule

// File: src/scale_stepper.sv
`timescale 1ns/10ps

module scale_stepper #(
    parameter int STEP_CYCLES = 100_000_000
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             cmd_up,
    input  logic             cmd_down,
    input  logic             cmd_fast,
    input  logic             cmd_slow,
    input  logic             cmd_restart,
    output scale_pkg::note_t note,
    output logic             going_up,
    output logic             fast
);

    import scale_pkg::*;

    localparam int FAST_CYCLES = STEP_CYCLES / 2;
    localparam int CNT_W       = $clog2(STEP_CYCLES);

    logic [CNT_W-1:0] step_cnt;     // cycles spent on the current note.
    logic [CNT_W-1:0] period_m1;    // last count of the current step period.
    logic             step_done;

    // ==============================
    // mode flags
    // ==============================

    always_ff @(posedge clk) begin
        if (rst) begin
            going_up <= 1'b1;
            fast     <= 1'b0;
        end else begin
            if (cmd_up) begin
                going_up <= 1'b1;
            end else if (cmd_down) begin
                going_up <= 1'b0;
            end
            if (cmd_fast) begin
                fast <= 1'b1;
            end else if (cmd_slow) begin
                fast <= 1'b0;
            end
        end
    end

    // ==============================
    // step timer and note index
    // ==============================

    assign period_m1 = fast ? CNT_W'(FAST_CYCLES - 1) : CNT_W'(STEP_CYCLES - 1);

    // greater or equal, so switching to fast halfway through a slow step
    // ends that step at once.
    assign step_done = (step_cnt >= period_m1);

    always_ff @(posedge clk) begin
        if (rst || cmd_restart) begin
            step_cnt <= '0;            // restart keeps direction and speed.
            note     <= '0;
        end else if (step_done) begin
            step_cnt <= '0;
            if (going_up && (note != NOTE_LAST)) begin
                note <= note + 4'd1;
            end else if (!going_up && (note != 4'd0)) begin
                note <= note - 4'd1;
            end
        end else begin
            step_cnt <= step_cnt + 1'b1;
        end
    end

    // the table in tone_gen has no entry past NOTE_LAST.
    a_note_range: assert property (
        @(posedge clk) disable iff (rst) note <= NOTE_LAST
    );

endmodule

// File: src/tone_gen.sv
`timescale 1ns/10ps

module tone_gen #(
    parameter int CLK_HZ = 100_000_000
) (
    input  logic             clk,
    input  logic             rst,
    input  scale_pkg::note_t note,
    output logic             audio
);

    import scale_pkg::*;

    // the lowest note has the longest half period and sets the counter width.
    localparam int MAX_HALF = half_period(note_t'(0), CLK_HZ);
    localparam int CNT_W    = $clog2(MAX_HALF + 1);

    logic [CNT_W-1:0] half_tab [0:NOTE_LAST];    // half period of every note.
    logic [CNT_W-1:0] half_sel;
    logic [CNT_W-1:0] tone_cnt;
    note_t            note_q;                    // note the wave is playing.

    // ==============================
    // half period table
    // ==============================

    genvar gi;
    generate
        for (gi = 0; gi <= NOTE_LAST; gi++) begin : g_tab
            localparam logic [31:0] HALF = half_period(note_t'(gi), CLK_HZ);

            assign half_tab[gi] = CNT_W'(HALF);

            // a zero entry would mean the clock is too slow for the note.
            a_tab_nonzero: assert property (
                @(posedge clk) half_tab[gi] != '0
            );
        end
    endgenerate

    assign half_sel = half_tab[note_q];

    // ==============================
    // square wave
    // ==============================

    always_ff @(posedge clk) begin
        if (rst) begin
            note_q   <= '0;
            tone_cnt <= '0;
            audio    <= 1'b0;
        end else if (note != note_q) begin
            note_q   <= note;          // new note starts from a clean low phase.
            tone_cnt <= '0;
            audio    <= 1'b0;
        end else if (tone_cnt == half_sel - 1'b1) begin
            tone_cnt <= '0;
            audio    <= ~audio;
        end else begin
            tone_cnt <= tone_cnt + 1'b1;
        end
    end

endmodule

// File: test/scale_player_tb.sv
`timescale 1ns/10ps

module scale_player_tb;

    import scale_pkg::*;

    localparam int CLK_HZ       = 1_000_000;
    localparam int STEP_CYCLES  = 4000;
    localparam int BIT_CYCLES   = 40;                  // one PS/2 bit in system cycles.
    localparam int FRAME_CYCLES = 11 * BIT_CYCLES;
    localparam int N_STEPS      = 18;
    localparam int MAX_HALF     = 1908;                // half period of C4 at 1 MHz.

    // note frequencies in Hz from C4 up to C6.
    localparam int unsigned NOTE_HZ [0:14] = '{262, 294, 330, 349, 392, 440, 494,
        524, 588, 660, 698, 784, 880, 988, 1048};

    typedef struct packed {
        logic [1:0]  n_bytes;
        scan_t [2:0] bytes;         // sent from index 0 upwards.
        logic        bad;           // every byte of the entry gets a wrong parity bit.
        logic [31:0] span;          // cycles from the start of the entry to the check.
        note_t       exp_note;
        logic        exp_up;
        logic        exp_fast;
    } entry_t;

    logic        clk;
    logic        rst;
    logic        ps2_clk;
    logic        ps2_data;
    logic        audio;
    note_t       note;
    logic        going_up;
    logic        fast;
    entry_t      steps [0:N_STEPS-1];
    int unsigned cycle_cnt = 0;
    int unsigned limit     = 32'hFFFF_FFFF;
    int          errors    = 0;
    int          checks    = 0;
    int          tests     = 0;

    scale_player #(
        .CLK_HZ      (CLK_HZ),
        .STEP_CYCLES (STEP_CYCLES)
    ) scale_player_i (
        .clk      (clk),
        .rst      (rst),
        .ps2_clk  (ps2_clk),
        .ps2_data (ps2_data),
        .audio    (audio),
        .note     (note),
        .going_up (going_up),
        .fast     (fast)
    );

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= limit) begin
            $display("timeout: the run did not finish within %0d clock cycles", limit);
            $display("STATUS: FAIL");
            $finish;
        end
    end

    // ==============================
    // checks and reporting
    // ==============================

    task automatic check_note(input string name, input note_t got, input note_t exp);
        checks++;
        if (got !== exp) begin
            $display("ERROR %s: expected 0x%0h, got 0x%0h", name, exp, got);
            errors++;
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            $display("ERROR %s: expected 0x%0h, got 0x%0h", name, exp, got);
            errors++;
        end
    endtask

    task automatic check_period(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            $display("ERROR %s: expected 0x%0h, got 0x%0h", name, exp, got);
            errors++;
        end
    endtask

    task automatic report_test(input string what, input int errs_before);
        tests++;
        $display("test %0d %s: %s", tests, what, (errors == errs_before) ? "ok" : "failed");
    endtask

    function automatic entry_t mk(input int n, input scan_t b0, input scan_t b1,
                                  input scan_t b2, input logic bad, input int span,
                                  input note_t exp_note, input logic exp_up,
                                  input logic exp_fast);
        entry_t e;
        e.n_bytes  = 2'(n);
        e.bytes    = {b2, b1, b0};
        e.bad      = bad;
        e.span     = 32'(span);
        e.exp_note = exp_note;
        e.exp_up   = exp_up;
        e.exp_fast = exp_fast;
        return e;
    endfunction

    // a full wave is two whole half periods, the remainder of each half is dropped.
    function automatic logic [31:0] tone_cycles(input note_t n);
        return 32'd2 * (CLK_HZ / (2 * NOTE_HZ[n]));
    endfunction

    // ==============================
    // stimulus
    // ==============================

    task automatic send_byte(input scan_t b, input logic bad);
        logic [10:0] frame;
        logic        parity;
        int          i;
        parity = ~(^b);                     // odd parity over data and parity bit.
        if (bad) begin
            parity = ~parity;
        end
        frame = {1'b1, parity, b, 1'b0};
        for (i = 0; i < 11; i++) begin
            ps2_data = frame[i];            // data moves while ps2_clk is high.
            repeat (BIT_CYCLES / 2) @(negedge clk);
            ps2_clk = 1'b0;
            repeat (BIT_CYCLES / 2) @(negedge clk);
            ps2_clk = 1'b1;
        end
    endtask

    task automatic wait_audio_rise(output int unsigned cycles);
        logic prev;
        logic seen;
        cycles = 0;
        seen   = 1'b0;
        prev   = audio;
        while (!seen) begin
            @(negedge clk);
            cycles = cycles + 1;
            seen   = !prev && audio;
            prev   = audio;
        end
    endtask

    task automatic measure_tone(input note_t n);
        int unsigned skipped;
        int unsigned period;
        int          errs_before;
        errs_before = errors;
        while (note != n) @(negedge clk);
        wait_audio_rise(skipped);           // the first edge only lines up the count.
        wait_audio_rise(period);
        if (note != n) begin
            $display("note moved away from %0d before its tone period was measured", n);
            errors++;
        end else begin
            check_period("audio period", period, tone_cycles(n));
        end
        report_test($sformatf("tone at note %0d", n), errs_before);
    endtask

    initial begin
        int          seed;
        int unsigned gap;
        int          used;
        int          rem;
        int          errs_before;
        int          total;
        int          i;
        int          k;
        clk      = 1'b0;
        rst      = 1'b1;
        ps2_clk  = 1'b1;
        ps2_data = 1'b1;
        seed     = $urandom(33);

        // samples fall in the middle of a step, far from any note change.
        steps[0]  = mk(0, 8'h00, 8'h00, 8'h00, 1'b0, 2000, 4'd0, 1'b1, 1'b0);
        steps[1]  = mk(0, 8'h00, 8'h00, 8'h00, 1'b0, 8000, 4'd2, 1'b1, 1'b0);
        steps[2]  = mk(0, 8'h00, 8'h00, 8'h00, 1'b0, 48000, 4'd14, 1'b1, 1'b0);
        steps[3]  = mk(0, 8'h00, 8'h00, 8'h00, 1'b0, 8000, 4'd14, 1'b1, 1'b0);
        steps[4]  = mk(1, KEY_S, 8'h00, 8'h00, 1'b0, 8000, 4'd12, 1'b0, 1'b0);
        steps[5]  = mk(0, 8'h00, 8'h00, 8'h00, 1'b0, 56000, 4'd0, 1'b0, 1'b0);
        steps[6]  = mk(1, KEY_W, 8'h00, 8'h00, 1'b0, 8000, 4'd2, 1'b1, 1'b0);
        steps[7]  = mk(2, BREAK_PREFIX, KEY_S, 8'h00, 1'b0, 8000, 4'd4, 1'b1, 1'b0);
        steps[8]  = mk(1, KEY_R, 8'h00, 8'h00, 1'b0, 5550, 4'd7, 1'b1, 1'b1);
        steps[9]  = mk(0, 8'h00, 8'h00, 8'h00, 1'b0, 10000, 4'd12, 1'b1, 1'b1);
        steps[10] = mk(1, KEY_F, 8'h00, 8'h00, 1'b0, 5000, 4'd13, 1'b1, 1'b0);
        steps[11] = mk(1, KEY_ENTER, 8'h00, 8'h00, 1'b0, 2550, 4'd0, 1'b1, 1'b0);
        steps[12] = mk(0, 8'h00, 8'h00, 8'h00, 1'b0, 8000, 4'd2, 1'b1, 1'b0);
        steps[13] = mk(1, KEY_R, 8'h00, 8'h00, 1'b0, 3550, 4'd4, 1'b1, 1'b1);
        steps[14] = mk(2, EXT_PREFIX, KEY_ENTER, 8'h00, 1'b0, 2115, 4'd0, 1'b1, 1'b1);
        steps[15] = mk(1, KEY_S, 8'h00, 8'h00, 1'b1, 2000, 4'd1, 1'b1, 1'b1);
        steps[16] = mk(1, KEY_S, 8'h00, 8'h00, 1'b0, 2000, 4'd0, 1'b0, 1'b1);
        steps[17] = mk(1, KEY_W, 8'h00, 8'h00, 1'b0, 40000, 4'd14, 1'b1, 1'b1);

        // the tone checks need one frame, a walk down the scale and three waves.
        total = 2 + FRAME_CYCLES + 200 + (NOTE_LAST + 1) * STEP_CYCLES / 2 + 12 * MAX_HALF;
        for (i = 0; i < N_STEPS; i++) begin
            total = total + int'(steps[i].span);
        end
        limit = total + total / 5;

        repeat (2) @(negedge clk);
        rst = 1'b0;

        for (i = 0; i < N_STEPS; i++) begin
            errs_before = errors;
            used        = 0;
            for (k = 0; k < steps[i].n_bytes; k++) begin
                gap = 50 + ($urandom % 151);
                repeat (gap) @(negedge clk);
                send_byte(steps[i].bytes[k], steps[i].bad);
                used = used + int'(gap) + FRAME_CYCLES;
            end
            rem = int'(steps[i].span) - used;
            if (rem < 0) begin
                $display("table entry %0d is too short for its key frames", i);
                errors++;
            end
            repeat (rem) @(negedge clk);
            check_note("note", note, steps[i].exp_note);
            check_flag("going_up", going_up, steps[i].exp_up);
            check_flag("fast", fast, steps[i].exp_fast);
            report_test($sformatf("table entry %0d", i), errs_before);
        end

        // ==============================
        // tone pitch
        // ==============================

        measure_tone(NOTE_LAST);            // held at the top of the scale.
        repeat (50 + ($urandom % 151)) @(negedge clk);
        send_byte(KEY_S, 1'b0);
        measure_tone(4'd12);                // caught on the way down.
        measure_tone(4'd0);                 // held at the bottom.

        $display("summary: %0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule
